/* filelist.f */
+incdir+rtl
rtl/a2_bus_pkg.sv
rtl/a2_shadow_pkg.sv
rtl/a2_interfaces.sv
rtl/a2_soft_switches.sv
rtl/a2_write_decoder.sv
rtl/a2_shadow_bank.sv
rtl/a2_video_reader.sv
rtl/a2_memory_top.sv
dv/tb_a2_memory.sv

/* Makefile */
TOP = tb_a2_memory

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* dv/tb_a2_memory.sv */
// Testbench for the Apple II shadow-memory monitor
// Table-driven switch, aux-select and shadow RAM checks against a byte model

`timescale 1ns/10ps

module tb_a2_memory
    import a2_bus_pkg::*;
    import a2_shadow_pkg::*;
();

    typedef enum logic [2:0] {K_SW, K_SW_NOSEL, K_SW_NOPHI, K_AUX, K_WR, K_RD} kind_e;

    // expected holds {iie, ii} for switch entries and aux_mem_o in bit 0 otherwise
    typedef struct packed {
        kind_e       kind;
        a2_addr_t    addr;
        a2_data_t    data;
        logic        rw_n;
        logic        m2b0;
        logic [15:0] expected;
    } entry_t;

    logic       clk;
    logic       rst_n;
    a2_addr_t   addr;
    a2_data_t   data;
    logic       rw_n;
    logic       strobe;
    logic       phi1;
    logic       m2sel_n;
    logic       m2b0;
    a2_addr_t   video_address;
    bank_word_t video_data_o;
    sw_ii_t     sw_ii_o;
    sw_iie_t    sw_iie_o;
    logic       aux_mem_o;

    integer     seed;
    entry_t     stim_q [$];
    // Shadow bytes indexed by aux bit and bus address
    logic [7:0] shadow_model [0:1][0:65535];

    a2_memory_top dut (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .addr_i           (addr),
        .data_i           (data),
        .rw_n_i           (rw_n),
        .data_in_strobe_i (strobe),
        .phi1_posedge_i   (phi1),
        .m2sel_n_i        (m2sel_n),
        .m2b0_i           (m2b0),
        .video_address_i  (video_address),
        .video_data_o     (video_data_o),
        .sw_ii_o          (sw_ii_o),
        .sw_iie_o         (sw_iie_o),
        .aux_mem_o        (aux_mem_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ---------------------------------------------------------------------------
    // Reference model and compare tasks
    // ---------------------------------------------------------------------------

    function automatic logic is_text_addr(input a2_addr_t a);
        return (a >= 16'h0400) && (a <= 16'h0BFF);
    endfunction

    function automatic logic is_hires_addr(input a2_addr_t a);
        return (a >= 16'h2000) && (a <= 16'h5FFF);
    endfunction

    // Both regions return the byte pair at the even address, aux above main
    function automatic bank_word_t expected_video(input a2_addr_t v);
        a2_addr_t b;
        if (!is_text_addr(v) && !is_hires_addr(v)) begin
            return '0;
        end
        b = {v[15:1], 1'b0};
        return {shadow_model[1][b + 16'd1], shadow_model[0][b + 16'd1],
                shadow_model[1][b], shadow_model[0][b]};
    endfunction

    task automatic stop_on_error();
        $display("*** FAILED ***");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_word(input string name, input bank_word_t got, input bank_word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_sw_ii(input sw_ii_t got, input sw_ii_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED: sw_ii_o got %h expected %h", got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_sw_iie(input sw_iie_t got, input sw_iie_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED: sw_iie_o got %h expected %h", got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while ($isunknown(sw_ii_o) || $isunknown(sw_iie_o) || $isunknown(video_data_o)) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 16) begin
                $display("Timeout: outputs still unknown after reset release");
                stop_on_error();
            end
        end
    endtask

    // ---------------------------------------------------------------------------
    // Stimulus table
    // ---------------------------------------------------------------------------

    task automatic add_entry(input kind_e k, input a2_addr_t a, input a2_data_t d,
                             input logic rw, input logic b0, input logic [15:0] exp);
        stim_q.push_back('{k, a, d, rw, b0, exp});
    endtask

    task automatic add_writes(input a2_addr_t base, input int count, input logic b0,
                              input logic exp_aux);
        for (int i = 0; i < count; i++) begin
            add_entry(K_WR, base + a2_addr_t'(i), a2_data_t'($random(seed)), 1'b0, b0,
                      {15'd0, exp_aux});
        end
    endtask

    task automatic build_table();
        add_entry(K_SW, 16'hC057, 8'h00, 1'b1, 1'b0, 16'h0089);
        add_entry(K_SW, 16'hC050, 8'h00, 1'b1, 1'b0, 16'h0088);
        add_entry(K_SW, 16'hC001, 8'h00, 1'b0, 1'b0, 16'h0188);
        // IIe switches ignore reads
        add_entry(K_SW, 16'hC001, 8'h00, 1'b1, 1'b0, 16'h0188);
        add_entry(K_SW, 16'hC068, 8'h70, 1'b0, 1'b0, 16'h078C);
        add_entry(K_SW, 16'hC068, 8'h41, 1'b0, 1'b0, 16'h098C);
        add_entry(K_SW, 16'hC068, 8'h70, 1'b0, 1'b0, 16'h078C);
        add_entry(K_SW_NOSEL, 16'hC051, 8'h00, 1'b1, 1'b0, 16'h078C);
        add_entry(K_SW_NOPHI, 16'hC000, 8'h00, 1'b0, 1'b0, 16'h078C);
        add_entry(K_SW_NOPHI, 16'hC068, 8'h00, 1'b0, 1'b0, 16'h078C);
        // STORE80, PAGE2 and HIRES set, ALTZP clear
        add_entry(K_AUX, 16'h0012, 8'h00, 1'b0, 1'b0, 16'h0000);
        add_entry(K_AUX, 16'h0500, 8'h00, 1'b1, 1'b0, 16'h0001);
        add_entry(K_AUX, 16'h2100, 8'h00, 1'b1, 1'b0, 16'h0001);
        add_entry(K_AUX, 16'h6000, 8'h00, 1'b0, 1'b0, 16'h0001);
        add_entry(K_AUX, 16'h6000, 8'h00, 1'b1, 1'b0, 16'h0000);
        add_entry(K_AUX, 16'hC100, 8'h00, 1'b0, 1'b0, 16'h0000);
        add_entry(K_SW, 16'hC009, 8'h00, 1'b0, 1'b0, 16'h178C);
        add_entry(K_SW, 16'hC056, 8'h00, 1'b1, 1'b0, 16'h1784);
        add_entry(K_AUX, 16'hFF00, 8'h00, 1'b1, 1'b0, 16'h0001);
        add_entry(K_AUX, 16'h0100, 8'h00, 1'b1, 1'b0, 16'h0001);
        add_entry(K_AUX, 16'h2100, 8'h00, 1'b1, 1'b0, 16'h0000);
        add_entry(K_AUX, 16'h2100, 8'h00, 1'b0, 1'b0, 16'h0001);
        add_entry(K_AUX, 16'h0800, 8'h00, 1'b1, 1'b0, 16'h0000);
        add_entry(K_SW, 16'hC000, 8'h00, 1'b0, 1'b0, 16'h1684);
        add_entry(K_AUX, 16'h0500, 8'h00, 1'b1, 1'b0, 16'h0000);
        add_entry(K_AUX, 16'h0500, 8'h00, 1'b0, 1'b0, 16'h0001);
        // Text, aux through m2b0 on page 1 and through RAMWRT on page 2
        add_entry(K_SW, 16'hC004, 8'h00, 1'b0, 1'b0, 16'h1284);
        add_writes(16'h0404, 2, 1'b0, 1'b0);
        add_writes(16'h0404, 2, 1'b1, 1'b0);
        add_entry(K_RD, 16'h0404, 8'h00, 1'b1, 1'b0, 16'h0000);
        add_entry(K_RD, 16'h0405, 8'h00, 1'b1, 1'b0, 16'h0000);
        add_writes(16'h0A20, 2, 1'b0, 1'b0);
        add_entry(K_SW, 16'hC005, 8'h00, 1'b0, 1'b0, 16'h1684);
        add_writes(16'h0A20, 2, 1'b0, 1'b1);
        add_entry(K_RD, 16'h0A21, 8'h00, 1'b1, 1'b0, 16'h0000);
        // Hires on both pages
        add_writes(16'h2468, 4, 1'b0, 1'b1);
        add_entry(K_SW, 16'hC004, 8'h00, 1'b0, 1'b0, 16'h1284);
        add_writes(16'h2468, 4, 1'b0, 1'b0);
        add_entry(K_RD, 16'h2468, 8'h00, 1'b1, 1'b0, 16'h0000);
        add_entry(K_RD, 16'h246A, 8'h00, 1'b1, 1'b0, 16'h0000);
        add_writes(16'h5FFC, 4, 1'b0, 1'b0);
        add_writes(16'h5FFC, 4, 1'b1, 1'b0);
        add_entry(K_RD, 16'h5FFD, 8'h00, 1'b1, 1'b0, 16'h0000);
        add_entry(K_RD, 16'h5FFF, 8'h00, 1'b1, 1'b0, 16'h0000);
        // Outside both regions
        add_writes(16'h03FE, 2, 1'b0, 1'b0);
        add_writes(16'h0C00, 2, 1'b0, 1'b0);
        add_writes(16'h1FFE, 2, 1'b0, 1'b0);
        add_writes(16'h6000, 1, 1'b0, 1'b0);
        add_entry(K_RD, 16'h03FF, 8'h00, 1'b1, 1'b0, 16'h0000);
        add_entry(K_RD, 16'h0C00, 8'h00, 1'b1, 1'b0, 16'h0000);
        add_entry(K_RD, 16'h1FFF, 8'h00, 1'b1, 1'b0, 16'h0000);
        add_entry(K_RD, 16'h6000, 8'h00, 1'b1, 1'b0, 16'h0000);
        add_entry(K_RD, 16'h0404, 8'h00, 1'b1, 1'b0, 16'h0000);
        add_entry(K_RD, 16'h0A20, 8'h00, 1'b1, 1'b0, 16'h0000);
        add_entry(K_RD, 16'h246A, 8'h00, 1'b1, 1'b0, 16'h0000);
    endtask

    // One entry per cycle, results checked 1 ns after the edge that takes it
    task automatic apply_entry(input entry_t e);
        logic aux;
        addr    = e.addr;
        data    = e.data;
        rw_n    = e.rw_n;
        m2b0    = e.m2b0;
        phi1    = (e.kind == K_SW) || (e.kind == K_SW_NOSEL);
        m2sel_n = (e.kind == K_SW_NOSEL);
        strobe  = (e.kind == K_WR);
        if (e.kind == K_RD) begin
            video_address = e.addr;
        end
        @(posedge clk);
        #1;
        phi1    = 1'b0;
        m2sel_n = 1'b1;
        strobe  = 1'b0;
        case (e.kind)
            K_SW, K_SW_NOSEL, K_SW_NOPHI: begin
                check_sw_ii(sw_ii_o, e.expected[7:0]);
                check_sw_iie(sw_iie_o, e.expected[15:8]);
            end
            K_AUX: check_bit("aux_mem_o", aux_mem_o, e.expected[0]);
            K_WR: begin
                check_bit("aux_mem_o", aux_mem_o, e.expected[0]);
                aux = e.expected[0] | e.m2b0;
                if (is_text_addr(e.addr) || is_hires_addr(e.addr)) begin
                    shadow_model[aux][e.addr] = e.data;
                end
            end
            default: check_word("video_data_o", video_data_o, expected_video(e.addr));
        endcase
    endtask

    initial begin
        integer i;
        rst_n         = 1'b0;
        addr          = 16'h0000;
        data          = 8'h00;
        rw_n          = 1'b1;
        strobe        = 1'b0;
        phi1          = 1'b0;
        m2sel_n       = 1'b1;
        m2b0          = 1'b0;
        video_address = 16'h0000;
        seed          = 32'hfbd1;
        build_table();

        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        wait_reset_release();
        check_sw_ii(sw_ii_o, 8'h81);
        check_sw_iie(sw_iie_o, 8'h00);
        check_word("video_data_o", video_data_o, '0);

        for (i = 0; i < stim_q.size(); i++) begin
            apply_entry(stim_q[i]);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* rtl/a2_memory_top.sv */
// Apple II shadow-memory monitor, top level
// Builds the bus interface from plain ports and wires switches, banks and reader

`timescale 1ns/10ps

`include "a2_macros.svh"

module a2_memory_top
    import a2_bus_pkg::*;
    import a2_shadow_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  a2_addr_t   addr_i,
    input  a2_data_t   data_i,
    input  logic       rw_n_i,
    input  logic       data_in_strobe_i,
    input  logic       phi1_posedge_i,
    input  logic       m2sel_n_i,
    input  logic       m2b0_i,
    input  a2_addr_t   video_address_i,
    output bank_word_t video_data_o,
    output sw_ii_t     sw_ii_o,
    output sw_iie_t    sw_iie_o,
    output logic       aux_mem_o
);

    a2bus_if     bus_if ();
    a2_switch_if sw_if ();
    shadow_wr_if wr_if [`NUM_BANKS] ();

    bank_addr_t rd_addr [`NUM_BANKS];
    bank_word_t rd_data [`NUM_BANKS];

    assign bus_if.clk            = clk_i;
    assign bus_if.rst_n          = rst_n_i;
    assign bus_if.addr           = addr_i;
    assign bus_if.data           = data_i;
    assign bus_if.rw_n           = rw_n_i;
    assign bus_if.data_in_strobe = data_in_strobe_i;
    assign bus_if.phi1_posedge   = phi1_posedge_i;
    assign bus_if.m2sel_n        = m2sel_n_i;
    assign bus_if.m2b0           = m2b0_i;

    // ---------------------------------------------------------------------------
    // Bus side
    // ---------------------------------------------------------------------------

    a2_soft_switches u_switches (
        .bus_if (bus_if),
        .sw_if  (sw_if)
    );

    a2_write_decoder u_decoder (
        .bus_if    (bus_if),
        .sw_if     (sw_if),
        .aux_mem_o (aux_mem_o),
        .wr_if     (wr_if)
    );

    assign sw_ii_o  = sw_if.sw_ii;
    assign sw_iie_o = sw_if.sw_iie;

    // ---------------------------------------------------------------------------
    // Shadow banks and video side
    // ---------------------------------------------------------------------------

    for (genvar g = 0; g < `NUM_BANKS; g++) begin : g_bank
        a2_shadow_bank u_bank (
            .clk_if    (bus_if),
            .wr_if     (wr_if[g]),
            .rd_addr_i (rd_addr[g]),
            .rd_data_o (rd_data[g])
        );
    end

    a2_video_reader u_reader (
        .clk_if          (bus_if),
        .video_address_i (video_address_i),
        .rd_addr_o       (rd_addr),
        .rd_data_i       (rd_data),
        .video_data_o    (video_data_o)
    );

endmodule

/* rtl/a2_video_reader.sv */
// Video scanner read port
// Maps scanner addresses to bank reads and merges main/aux hires bytes

`timescale 1ns/10ps

`include "a2_macros.svh"

module a2_video_reader
    import a2_bus_pkg::*;
    import a2_shadow_pkg::*;
(
    a2bus_if.clock     clk_if,
    input a2_addr_t    video_address_i,
    output bank_addr_t rd_addr_o [`NUM_BANKS],
    input bank_word_t  rd_data_i [`NUM_BANKS],
    output bank_word_t video_data_o
);

    logic in_text;
    logic in_hires;
    logic text_q;
    logic hires_q;
    logic hi_half_q;

    assign in_text  = video_address_i[15:10] inside {6'b000001, 6'b000010};
    assign in_hires = video_address_i[15:13] inside {3'b001, 3'b010};

    // Text words hold two scanner bytes, main and aux each
    assign rd_addr_o[BANK_TEXT]       = {2'b00, !video_address_i[10], video_address_i[9:1]};
    assign rd_addr_o[BANK_HIRES_MAIN] = {!video_address_i[13], video_address_i[12:2]};
    assign rd_addr_o[BANK_HIRES_AUX]  = {!video_address_i[13], video_address_i[12:2]};

    // ---------------------------------------------------------------------------
    // Region select, one cycle behind the address like the RAM data
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk_if.clk) begin
        if (!clk_if.rst_n) begin
            text_q    <= 1'b0;
            hires_q   <= 1'b0;
            hi_half_q <= 1'b0;
        end else begin
            text_q    <= in_text;
            hires_q   <= in_hires;
            hi_half_q <= video_address_i[1];
        end
    end

    always_comb begin
        if (text_q) begin
            video_data_o = rd_data_i[BANK_TEXT];
        end else if (hires_q && hi_half_q) begin
            // Aux byte above main byte in each lane pair
            video_data_o = {rd_data_i[BANK_HIRES_AUX][31:24], rd_data_i[BANK_HIRES_MAIN][31:24],
                            rd_data_i[BANK_HIRES_AUX][23:16], rd_data_i[BANK_HIRES_MAIN][23:16]};
        end else if (hires_q) begin
            video_data_o = {rd_data_i[BANK_HIRES_AUX][15:8], rd_data_i[BANK_HIRES_MAIN][15:8],
                            rd_data_i[BANK_HIRES_AUX][7:0], rd_data_i[BANK_HIRES_MAIN][7:0]};
        end else begin
            video_data_o = '0;
        end
    end

endmodule

/* rtl/a2_shadow_bank.sv */
// One shadow RAM bank
// 4096 x 32 simple dual-port memory with byte-lane writes and registered read

`timescale 1ns/10ps

`include "a2_macros.svh"

module a2_shadow_bank
    import a2_shadow_pkg::*;
(
    a2bus_if.clock     clk_if,
    shadow_wr_if.slave wr_if,
    input bank_addr_t  rd_addr_i,
    output bank_word_t rd_data_o
);

    localparam int DEPTH = 1 << `BANK_ADDR_W;
    localparam int LANES = `BANK_WORD_W / 8;

    bank_word_t mem [DEPTH];

    // ---------------------------------------------------------------------------
    // Write and read ports
    // ---------------------------------------------------------------------------

    // Same-word read and write in one cycle returns the old word
    always_ff @(posedge clk_if.clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (wr_if.we && wr_if.be[i]) begin
                mem[wr_if.addr][i*8 +: 8] <= wr_if.data[i*8 +: 8];
            end
        end
        rd_data_o <= mem[rd_addr_i];
    end

    // The decoder writes exactly one byte per bus cycle
    a_single_lane: assert property (
        @(posedge clk_if.clk) disable iff (!clk_if.rst_n)
        wr_if.we |-> $onehot(wr_if.be)
    );

endmodule

/* rtl/a2_write_decoder.sv */
// Shadow write decoder
// Works out the main/aux bank select and turns bus writes into bank writes

`timescale 1ns/10ps

`include "a2_macros.svh"

module a2_write_decoder
    import a2_bus_pkg::*;
    import a2_shadow_pkg::*;
(
    a2bus_if.monitor    bus_if,
    a2_switch_if.sink   sw_if,
    output logic        aux_mem_o,
    shadow_wr_if.master wr_if [`NUM_BANKS]
);

    sw_ii_t               sw_ii;
    sw_iie_t              sw_iie;
    logic                 write_strobe;
    logic                 ramwrt_wr;
    logic                 aux_sel;
    logic                 aux_bit;
    logic                 in_text;
    logic                 in_hires;
    logic [11:0]          text_off;
    logic [2:0]           hires_blk;
    logic [15:0]          hires_off;
    logic [`NUM_BANKS-1:0] bank_we;
    bank_addr_t           bank_addr [`NUM_BANKS];
    byte_en_t             bank_be [`NUM_BANKS];
    bank_word_t           write_word;

    assign sw_ii  = sw_if.sw_ii;
    assign sw_iie = sw_if.sw_iie;

    assign write_strobe = !bus_if.rw_n && bus_if.data_in_strobe;
    assign ramwrt_wr    = sw_iie[RAMWRT] && !bus_if.rw_n;

    // ---------------------------------------------------------------------------
    // Main/aux select per page class
    // ---------------------------------------------------------------------------

    always_comb begin
        if (bus_if.addr[15:9] == 7'b0000000 || bus_if.addr[15:14] == 2'b11) begin
            // Zero page, stack and C0-FF
            aux_sel = sw_iie[ALTZP];
        end else if (bus_if.addr[15:10] == 6'b000001) begin
            // Text page 1
            aux_sel = (sw_iie[STORE80] && sw_ii[PAGE2]) || (!sw_iie[STORE80] && ramwrt_wr);
        end else if (bus_if.addr[15:13] == 3'b001) begin
            // Hires page 1
            aux_sel = (sw_iie[STORE80] && sw_ii[PAGE2] && sw_ii[HIRES_MODE])
                   || ((!sw_iie[STORE80] || !sw_ii[HIRES_MODE]) && ramwrt_wr);
        end else begin
            aux_sel = ramwrt_wr;
        end
    end

    assign aux_mem_o = aux_sel;
    // m2b0 forces aux for cards that drive the aux bank directly
    assign aux_bit   = aux_sel || bus_if.m2b0;

    // ---------------------------------------------------------------------------
    // Region decode and bank offsets
    // ---------------------------------------------------------------------------

    assign in_text  = bus_if.addr[15:10] inside {6'b000001, 6'b000010};
    assign in_hires = bus_if.addr[15:13] inside {3'b001, 3'b010};

    // Main and aux text bytes sit side by side in one word
    assign text_off  = {!bus_if.addr[10], bus_if.addr[9:0], aux_bit};
    assign hires_blk = bus_if.addr[15:13] - 3'd1;
    assign hires_off = {hires_blk, bus_if.addr[12:0]};

    assign write_word = {4{bus_if.data}};

    assign bank_we[BANK_TEXT]       = write_strobe && in_text;
    assign bank_we[BANK_HIRES_MAIN] = write_strobe && in_hires && !aux_bit;
    assign bank_we[BANK_HIRES_AUX]  = write_strobe && in_hires && aux_bit;

    assign bank_addr[BANK_TEXT]       = {2'b00, text_off[11:2]};
    assign bank_addr[BANK_HIRES_MAIN] = hires_off[13:2];
    assign bank_addr[BANK_HIRES_AUX]  = hires_off[13:2];

    assign bank_be[BANK_TEXT]       = byte_en_t'(4'b0001 << text_off[1:0]);
    assign bank_be[BANK_HIRES_MAIN] = byte_en_t'(4'b0001 << hires_off[1:0]);
    assign bank_be[BANK_HIRES_AUX]  = byte_en_t'(4'b0001 << hires_off[1:0]);

    for (genvar g = 0; g < `NUM_BANKS; g++) begin : g_wr
        assign wr_if[g].we   = bank_we[g];
        assign wr_if[g].addr = bank_addr[g];
        assign wr_if[g].data = write_word;
        assign wr_if[g].be   = bank_be[g];
    end

    a_one_bank_write: assert property (
        @(posedge bus_if.clk) disable iff (!bus_if.rst_n)
        $onehot0(bank_we)
    );

endmodule

/* rtl/a2_soft_switches.sv */
// Apple II soft-switch capture
// Tracks the II display switches and the IIe auxiliary memory switches

`timescale 1ns/10ps

`include "a2_macros.svh"

module a2_soft_switches
    import a2_bus_pkg::*;
(
    a2bus_if.monitor    bus_if,
    a2_switch_if.source sw_if
);

    sw_ii_t  sw_ii_q;
    sw_iie_t sw_iie_q;
    logic    sw_access;
    logic    sw_write;
    logic    page_ii;
    logic    page_iie;
    logic    ctrl_hit;

    // Switch accesses are only valid at phi1 with the slot select low
    assign sw_access = bus_if.phi1_posedge && !bus_if.m2sel_n;
    assign sw_write  = sw_access && !bus_if.rw_n;

    assign page_ii  = ({4'h0, bus_if.addr[15:4]} == `SW_II_PAGE);
    assign page_iie = ({4'h0, bus_if.addr[15:4]} == `SW_IIE_PAGE);
    assign ctrl_hit = (bus_if.addr == `SW_CTRL_ADDR);

    // ---------------------------------------------------------------------------
    // Switch registers
    // ---------------------------------------------------------------------------

    always_ff @(posedge bus_if.clk) begin
        if (!bus_if.rst_n) begin
            sw_ii_q  <= SW_II_RESET;
            sw_iie_q <= '0;
        end else begin
            // II switches toggle on any access, read or write
            if (sw_access && page_ii) begin
                sw_ii_q[bus_if.addr[3:1]] <= bus_if.addr[0];
            end else if (sw_write && ctrl_hit) begin
                sw_ii_q[PAGE2] <= bus_if.data[6];
            end

            // IIe switches only respond to writes
            if (sw_write && page_iie) begin
                sw_iie_q[bus_if.addr[3:1]] <= bus_if.addr[0];
            end else if (sw_write && ctrl_hit) begin
                sw_iie_q[RAMRD]    <= bus_if.data[5];
                sw_iie_q[RAMWRT]   <= bus_if.data[4];
                sw_iie_q[INTCXROM] <= bus_if.data[0];
            end
        end
    end

    assign sw_if.sw_ii  = sw_ii_q;
    assign sw_if.sw_iie = sw_iie_q;

    // Switch state only moves on a phi1 cycle
    a_no_change_off_phi1: assert property (
        @(posedge bus_if.clk)
        bus_if.rst_n && !bus_if.phi1_posedge |=> $stable(sw_ii_q) && $stable(sw_iie_q)
    );

endmodule

/* rtl/a2_interfaces.sv */
// Interfaces of the shadow-memory monitor
// The 6502 bus, the soft-switch state and one bank write port

`timescale 1ns/10ps

// 6502 bus as seen by the monitor
interface a2bus_if
    import a2_bus_pkg::*;
();
    logic     clk;
    logic     rst_n;
    a2_addr_t addr;
    a2_data_t data;
    logic     rw_n;
    logic     data_in_strobe;
    logic     phi1_posedge;
    logic     m2sel_n;
    logic     m2b0;

    // Passive watcher of every bus signal
    modport monitor (
        input clk,
        input rst_n,
        input addr,
        input data,
        input rw_n,
        input data_in_strobe,
        input phi1_posedge,
        input m2sel_n,
        input m2b0
    );

    // Clock and reset only, for the memory side
    modport clock (
        input clk,
        input rst_n
    );
endinterface

// Current soft-switch state
interface a2_switch_if
    import a2_bus_pkg::*;
();
    sw_ii_t  sw_ii;
    sw_iie_t sw_iie;

    modport source (output sw_ii, output sw_iie);
    modport sink (input sw_ii, input sw_iie);
endinterface

// Write port of one shadow bank
interface shadow_wr_if
    import a2_shadow_pkg::*;
();
    logic       we;
    bank_addr_t addr;
    bank_word_t data;
    byte_en_t   be;

    modport master (output we, output addr, output data, output be);
    modport slave (input we, input addr, input data, input be);
endinterface

/* rtl/a2_shadow_pkg.sv */
// Shadow-memory types
// RAM word, word address, byte lanes and the bank numbering

`include "a2_macros.svh"

package a2_shadow_pkg;

    // One RAM word holds four bus bytes
    typedef logic [`BANK_WORD_W-1:0] bank_word_t;

    // Word address inside one bank
    typedef logic [`BANK_ADDR_W-1:0] bank_addr_t;

    // One enable per byte lane
    typedef logic [`BANK_WORD_W/8-1:0] byte_en_t;

    // ---------------------------------------------------------------------------
    // Bank numbering
    // ---------------------------------------------------------------------------

    // Text uses only the lower 1024 words of its bank
    typedef enum logic [1:0] {
        BANK_TEXT       = 2'd0,
        BANK_HIRES_MAIN = 2'd1,
        BANK_HIRES_AUX  = 2'd2
    } bank_idx_e;

endpackage

/* rtl/a2_bus_pkg.sv */
// Apple II bus-side types
// Address and data words plus the two soft-switch banks with bit indices

`include "a2_macros.svh"

package a2_bus_pkg;

    typedef logic [`A2_ADDR_W-1:0] a2_addr_t;
    typedef logic [`A2_DATA_W-1:0] a2_data_t;

    // Original II display switches, C050-C05F
    typedef logic [7:0] sw_ii_t;
    localparam int TEXT_MODE  = 0;
    localparam int MIXED_MODE = 1;
    localparam int PAGE2      = 2;
    localparam int HIRES_MODE = 3;
    localparam int AN0        = 4;
    localparam int AN1        = 5;
    localparam int AN2        = 6;
    localparam int AN3        = 7;

    // Power-up state: text mode with AN3 set
    localparam sw_ii_t SW_II_RESET = 8'h81;

    // IIe auxiliary switches, C000-C00F writes
    typedef logic [7:0] sw_iie_t;
    localparam int STORE80   = 0;
    localparam int RAMRD     = 1;
    localparam int RAMWRT    = 2;
    localparam int INTCXROM  = 3;
    localparam int ALTZP     = 4;
    localparam int SLOTC3ROM = 5;
    localparam int COL80     = 6;
    localparam int ALTCHAR   = 7;

endpackage

/* rtl/a2_macros.svh */
// Apple II shadow-memory monitor constants
// Bus widths, shadow bank geometry and soft-switch addresses

`ifndef A2_MACROS_SVH
`define A2_MACROS_SVH

// 6502 bus
`define A2_ADDR_W 16
`define A2_DATA_W 8

// Shadow RAM banks: text, hires main, hires aux
`define BANK_WORD_W 32
`define BANK_ADDR_W 12
`define NUM_BANKS 3

// ---------------------------------------------------------------------------
// Soft-switch decode
// ---------------------------------------------------------------------------

// Pages are compared against addr[15:4]
`define SW_II_PAGE 16'hC05
`define SW_IIE_PAGE 16'hC00
// Combined state register (PAGE2, RAMRD, RAMWRT, INTCXROM)
`define SW_CTRL_ADDR 16'hC068

`endif
